// File: adam_cfg_pkg.sv
`default_nettype none

package adam_cfg_pkg;

    localparam int ADDR_WIDTH = 16;
    localparam int DATA_WIDTH = 32;
    localparam int OFFSET_WIDTH = 12;

    typedef logic [ADDR_WIDTH-1:0]   addr_t;
    typedef logic [DATA_WIDTH-1:0]   data_t;
    typedef logic [OFFSET_WIDTH-1:0] offset_t;

    // region select bits within the byte address
    localparam int REGION_MSB = 13;
    localparam int REGION_LSB = 12;

    typedef enum logic [1:0] {
        REG_SYSCFG = 2'd0,
        REG_LSPA   = 2'd1,
        REG_LSPB   = 2'd2,
        REG_NONE   = 2'd3
    } region_e;

    // peripheral register map
    localparam offset_t PER_COUNT   = 12'h000;
    localparam offset_t PER_COMPARE = 12'h004;
    localparam offset_t PER_CTRL    = 12'h008;
    localparam offset_t PER_IRQ     = 12'h00C;
    localparam offset_t PER_GPIO    = 12'h010;

    // syscfg register map
    localparam offset_t CFG_CTRL     = 12'h000;
    localparam offset_t CFG_STATUS   = 12'h004;
    localparam offset_t CFG_IRQ_PEND = 12'h008;
    localparam offset_t CFG_IRQ_EN   = 12'h00C;

endpackage

`default_nettype wire

// File: adam_bus_pkg.sv
`default_nettype none

package adam_bus_pkg;

    import adam_cfg_pkg::*;

    // one-cycle request strobe, no handshake
    typedef struct packed {
        logic  valid;
        logic  write;
        addr_t addr;
        data_t wdata;
    } bus_req_t;

    // response comes back the cycle after the strobe
    typedef struct packed {
        logic  valid;
        data_t rdata;
    } bus_rsp_t;

    // syscfg to peripheral
    typedef struct packed {
        logic rst;
        logic pause_req;
    } periph_ctrl_t;

    // peripheral to syscfg
    typedef struct packed {
        logic pause_ack;
        logic irq;
    } periph_stat_t;

endpackage

`default_nettype wire

// File: adam_fabric.sv
`timescale 1ns/10ps
`default_nettype none

module adam_fabric import adam_cfg_pkg::*, adam_bus_pkg::*; (
    input  logic     clk,
    input  logic     arst_n,

    input  bus_req_t req,
    output bus_rsp_t rsp,

    output bus_req_t syscfg_req,
    input  bus_rsp_t syscfg_rsp,

    output bus_req_t lspa_req,
    input  bus_rsp_t lspa_rsp,

    output bus_req_t lspb_req,
    input  bus_rsp_t lspb_rsp
);

    region_e req_region;
    region_e rsp_region_q;
    logic    none_valid_q;

    assign req_region = region_e'(req.addr[REGION_MSB:REGION_LSB]);

    // fan the request out, only the strobe is qualified
    always_comb begin
        syscfg_req = req;
        lspa_req   = req;
        lspb_req   = req;

        syscfg_req.valid = req.valid && (req_region == REG_SYSCFG);
        lspa_req.valid   = req.valid && (req_region == REG_LSPA);
        lspb_req.valid   = req.valid && (req_region == REG_LSPB);
    end

    // remember where the response will come from
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rsp_region_q <= REG_NONE;
            none_valid_q <= 1'b0;
        end
        else begin
            if (req.valid) begin
                rsp_region_q <= req_region;
            end
            // unmapped accesses are answered here
            none_valid_q <= req.valid && (req_region == REG_NONE);
        end
    end

    always_comb begin
        case (rsp_region_q)
            REG_SYSCFG: rsp = syscfg_rsp;
            REG_LSPA:   rsp = lspa_rsp;
            REG_LSPB:   rsp = lspb_rsp;
            default: begin
                rsp.valid = none_valid_q;
                rsp.rdata = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: adam_periph.sv
`timescale 1ns/10ps
`default_nettype none

module adam_periph import adam_cfg_pkg::*, adam_bus_pkg::*; #(
    parameter int unsigned GPIO_WIDTH = 8
) (
    input  logic                  clk,
    input  logic                  arst_n,

    input  bus_req_t              req,
    output bus_rsp_t              rsp,

    input  periph_ctrl_t          ctrl,
    output periph_stat_t          stat,

    output logic [GPIO_WIDTH-1:0] gpio
);

    offset_t off;
    logic    wr_en;
    logic    running;
    logic    match;
    data_t   rdata;

    data_t                 count_q;
    data_t                 compare_q;
    logic                  enable_q;
    logic                  flag_q;
    logic [GPIO_WIDTH-1:0] gpio_q;
    logic                  pause_ack_q;

    logic  rsp_valid_q;
    data_t rsp_rdata_q;

    assign off = req.addr[OFFSET_WIDTH-1:0];

    assign wr_en = req.valid && req.write;

    // counter stops once the pause is acknowledged
    assign running = enable_q && !pause_ack_q;
    assign match   = running && (count_q == compare_q);

    // pause acknowledge one cycle behind the request
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pause_ack_q <= 1'b0;
        end
        else begin
            pause_ack_q <= ctrl.pause_req;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            count_q   <= '0;
            compare_q <= '0;
            enable_q  <= 1'b0;
            flag_q    <= 1'b0;
            gpio_q    <= '0;
        end
        // soft reset holds every register and drops writes
        else if (ctrl.rst) begin
            count_q   <= '0;
            compare_q <= '0;
            enable_q  <= 1'b0;
            flag_q    <= 1'b0;
            gpio_q    <= '0;
        end
        else begin
            if (match) begin
                count_q <= '0;
            end
            else if (running) begin
                count_q <= count_q + data_t'(1);
            end

            if (wr_en && (off == PER_COMPARE)) begin
                compare_q <= req.wdata;
            end
            if (wr_en && (off == PER_CTRL)) begin
                enable_q <= req.wdata[0];
            end
            if (wr_en && (off == PER_GPIO)) begin
                gpio_q <= req.wdata[GPIO_WIDTH-1:0];
            end

            // a new match wins over a clear in the same cycle
            if (match) begin
                flag_q <= 1'b1;
            end
            else if (wr_en && (off == PER_IRQ) && req.wdata[0]) begin
                flag_q <= 1'b0;
            end
        end
    end

    always_comb begin
        rdata = '0;
        if (!ctrl.rst) begin
            case (off)
                PER_COUNT:   rdata = count_q;
                PER_COMPARE: rdata = compare_q;
                PER_CTRL:    rdata[0] = enable_q;
                PER_IRQ:     rdata[0] = flag_q;
                PER_GPIO:    rdata[GPIO_WIDTH-1:0] = gpio_q;
                default:     rdata = '0;
            endcase
        end
    end

    // read data sampled before the write lands
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rsp_valid_q <= 1'b0;
        end
        else begin
            rsp_valid_q <= req.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (req.valid) begin
            rsp_rdata_q <= rdata;
        end
    end

    assign rsp.valid      = rsp_valid_q;
    assign rsp.rdata      = rsp_rdata_q;
    assign stat.pause_ack = pause_ack_q;
    assign stat.irq       = flag_q;
    assign gpio           = gpio_q;

endmodule

`default_nettype wire

// File: adam_syscfg.sv
`timescale 1ns/10ps
`default_nettype none

module adam_syscfg import adam_cfg_pkg::*, adam_bus_pkg::*; (
    input  logic         clk,
    input  logic         arst_n,

    input  bus_req_t     req,
    output bus_rsp_t     rsp,

    output periph_ctrl_t lspa_ctrl,
    input  periph_stat_t lspa_stat,

    output periph_ctrl_t lspb_ctrl,
    input  periph_stat_t lspb_stat,

    output logic         irq
);

    offset_t off;
    logic    wr_en;
    data_t   rdata;

    // bit 0/1 soft resets, bit 2/3 pause requests
    logic [3:0] ctrl_q;
    logic [1:0] irq_en_q;
    logic       irq_q;

    logic [1:0] pause_status;
    logic [1:0] irq_pend;

    logic  rsp_valid_q;
    data_t rsp_rdata_q;

    assign off   = req.addr[OFFSET_WIDTH-1:0];
    assign wr_en = req.valid && req.write;

    // live view of both peripherals
    assign pause_status = {lspb_stat.pause_ack, lspa_stat.pause_ack};
    assign irq_pend     = {lspb_stat.irq, lspa_stat.irq};

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ctrl_q   <= '0;
            irq_en_q <= '0;
        end
        else begin
            if (wr_en && (off == CFG_CTRL)) begin
                ctrl_q <= req.wdata[3:0];
            end
            if (wr_en && (off == CFG_IRQ_EN)) begin
                irq_en_q <= req.wdata[1:0];
            end
        end
    end

    assign lspa_ctrl.rst       = ctrl_q[0];
    assign lspb_ctrl.rst       = ctrl_q[1];
    assign lspa_ctrl.pause_req = ctrl_q[2];
    assign lspb_ctrl.pause_req = ctrl_q[3];

    // masked interrupt, one register stage
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            irq_q <= 1'b0;
        end
        else begin
            irq_q <= |(irq_pend & irq_en_q);
        end
    end

    assign irq = irq_q;

    always_comb begin
        rdata = '0;
        case (off)
            CFG_CTRL:     rdata[3:0] = ctrl_q;
            CFG_STATUS:   rdata[1:0] = pause_status;
            CFG_IRQ_PEND: rdata[1:0] = irq_pend;
            CFG_IRQ_EN:   rdata[1:0] = irq_en_q;
            default:      rdata = '0;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rsp_valid_q <= 1'b0;
        end
        else begin
            rsp_valid_q <= req.valid;
        end
    end

    // value from before a write in the same cycle
    always_ff @(posedge clk) begin
        if (req.valid) begin
            rsp_rdata_q <= rdata;
        end
    end

    assign rsp.valid = rsp_valid_q;
    assign rsp.rdata = rsp_rdata_q;

endmodule

`default_nettype wire

// File: adam_lite.sv
`timescale 1ns/10ps
`default_nettype none

module adam_lite import adam_bus_pkg::*; #(
    parameter int unsigned GPIO_WIDTH = 8
) (
    input  logic                  clk,
    input  logic                  arst_n,

    input  bus_req_t              req,
    output bus_rsp_t              rsp,

    output logic [GPIO_WIDTH-1:0] lspa_gpio,
    output logic [GPIO_WIDTH-1:0] lspb_gpio,

    output logic                  irq
);

    bus_req_t syscfg_req;
    bus_rsp_t syscfg_rsp;
    bus_req_t lspa_req;
    bus_rsp_t lspa_rsp;
    bus_req_t lspb_req;
    bus_rsp_t lspb_rsp;

    periph_ctrl_t lspa_ctrl;
    periph_stat_t lspa_stat;
    periph_ctrl_t lspb_ctrl;
    periph_stat_t lspb_stat;

    adam_fabric adam_fabric (
        .clk        (clk),
        .arst_n     (arst_n),
        .req        (req),
        .rsp        (rsp),
        .syscfg_req (syscfg_req),
        .syscfg_rsp (syscfg_rsp),
        .lspa_req   (lspa_req),
        .lspa_rsp   (lspa_rsp),
        .lspb_req   (lspb_req),
        .lspb_rsp   (lspb_rsp)
    );

    // two identical peripheral blocks
    adam_periph #(
        .GPIO_WIDTH (GPIO_WIDTH)
    ) adam_periph_lspa (
        .clk    (clk),
        .arst_n (arst_n),
        .req    (lspa_req),
        .rsp    (lspa_rsp),
        .ctrl   (lspa_ctrl),
        .stat   (lspa_stat),
        .gpio   (lspa_gpio)
    );

    adam_periph #(
        .GPIO_WIDTH (GPIO_WIDTH)
    ) adam_periph_lspb (
        .clk    (clk),
        .arst_n (arst_n),
        .req    (lspb_req),
        .rsp    (lspb_rsp),
        .ctrl   (lspb_ctrl),
        .stat   (lspb_stat),
        .gpio   (lspb_gpio)
    );

    adam_syscfg adam_syscfg (
        .clk       (clk),
        .arst_n    (arst_n),
        .req       (syscfg_req),
        .rsp       (syscfg_rsp),
        .lspa_ctrl (lspa_ctrl),
        .lspa_stat (lspa_stat),
        .lspb_ctrl (lspb_ctrl),
        .lspb_stat (lspb_stat),
        .irq       (irq)
    );

endmodule

`default_nettype wire

// File: tb_adam_model.svh
`ifndef TB_ADAM_MODEL_SVH
`define TB_ADAM_MODEL_SVH

// xorshift32 state from a fixed seed
logic [31:0] rng_state = 32'd93361;

// index 0 is lspa in the model arrays
data_t             m_compare [2];
logic              m_enable  [2];
logic [GPIO_W-1:0] m_gpio    [2];
logic [3:0]        m_cfg_ctrl = '0;
logic [1:0]        m_irq_en   = '0;

function automatic logic [31:0] next_random();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
endfunction

function automatic void clear_periph_model(int idx);
    m_compare[idx] = '0;
    m_enable[idx]  = 1'b0;
    m_gpio[idx]    = '0;
endfunction

// expected read data of the modelled registers
function automatic data_t model_read(addr_t addr);
    region_e region;
    int      idx;
    data_t   value;
    region = region_e'(addr[13:12]);
    idx    = (region == REG_LSPB) ? 1 : 0;
    value  = '0;
    if (region == REG_SYSCFG) begin
        case (addr[11:0])
            CFG_CTRL:   value = {28'd0, m_cfg_ctrl};
            CFG_IRQ_EN: value = {30'd0, m_irq_en};
            default:    value = '0;
        endcase
    end
    else if (region != REG_NONE && !m_cfg_ctrl[idx]) begin
        case (addr[11:0])
            PER_COMPARE: value = m_compare[idx];
            PER_CTRL:    value = {31'd0, m_enable[idx]};
            PER_GPIO:    value = data_t'(m_gpio[idx]);
            default:     value = '0;
        endcase
    end
    return value;
endfunction

function automatic void model_write(addr_t addr, data_t data);
    region_e region;
    int      idx;
    region = region_e'(addr[13:12]);
    idx    = (region == REG_LSPB) ? 1 : 0;
    if (region == REG_SYSCFG) begin
        case (addr[11:0])
            CFG_CTRL:   m_cfg_ctrl = data[3:0];
            CFG_IRQ_EN: m_irq_en = data[1:0];
            default:    ;
        endcase
        // a held soft reset wipes that peripheral
        for (int p = 0; p < 2; p++) begin
            if (m_cfg_ctrl[p]) begin
                clear_periph_model(p);
            end
        end
    end
    else if (region != REG_NONE && !m_cfg_ctrl[idx]) begin
        case (addr[11:0])
            PER_COMPARE: m_compare[idx] = data;
            PER_CTRL:    m_enable[idx] = data[0];
            PER_GPIO:    m_gpio[idx] = data[GPIO_W-1:0];
            default:     ;
        endcase
    end
endfunction

`endif

// File: tb_adam_lite.sv
`timescale 1ns/10ps
`default_nettype none

module tb_adam_lite import adam_cfg_pkg::*, adam_bus_pkg::*; ();

    localparam int GPIO_W  = 8;
    localparam int TIMEOUT = 64;

    logic              clk = 1'b0;
    logic              arst_n;
    bus_req_t          req;
    bus_rsp_t          rsp;
    logic [GPIO_W-1:0] lspa_gpio;
    logic [GPIO_W-1:0] lspb_gpio;
    logic              irq;

    int error_count   = 0;
    int timeout_count = 0;
    int check_count   = 0;

    `include "tb_adam_model.svh"

    adam_lite #(
        .GPIO_WIDTH (GPIO_W)
    ) dut_i (
        .clk       (clk),
        .arst_n    (arst_n),
        .req       (req),
        .rsp       (rsp),
        .lspa_gpio (lspa_gpio),
        .lspb_gpio (lspb_gpio),
        .irq       (irq)
    );

    always #10 clk = ~clk;

    function automatic addr_t reg_addr(region_e region, offset_t off);
        return {2'b00, region, off};
    endfunction

    function automatic addr_t periph_addr(int p, offset_t off);
        return reg_addr((p == 0) ? REG_LSPA : REG_LSPB, off);
    endfunction

    task automatic check_equal(string name, data_t got, data_t exp);
        check_count++;
        assert (got == exp) else begin
            $display("ERROR: %s got %h expected %h", name, got, exp);
            error_count++;
        end
    endtask

    task automatic apply_reset();
        req    <= '0;
        arst_n <= 1'b0;
        clear_periph_model(0);
        clear_periph_model(1);
        repeat (4) @(posedge clk);
        arst_n <= 1'b1;
        @(negedge clk);
    endtask

    // one-cycle strobe with the response sampled at the falling edge
    task automatic bus_access(logic is_write, addr_t addr, data_t wdata, output data_t rdata);
        int n;
        @(posedge clk);
        req <= '{valid: 1'b1, write: is_write, addr: addr, wdata: wdata};
        @(posedge clk);
        req.valid <= 1'b0;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!rsp.valid && n < TIMEOUT);
        if (!rsp.valid) begin
            $display("timeout waiting for a bus response to address %h", addr);
            timeout_count++;
        end
        else begin
            check_equal("rsp.valid latency", data_t'(n), 32'd1);
        end
        rdata = rsp.rdata;
        if (is_write) begin
            model_write(addr, wdata);
        end
    endtask

    task automatic write_reg(addr_t addr, data_t data);
        data_t ignored;
        bus_access(1'b1, addr, data, ignored);
    endtask

    task automatic read_expect(string name, addr_t addr);
        data_t got;
        bus_access(1'b0, addr, '0, got);
        check_equal($sformatf("rsp.rdata %s", name), got, model_read(addr));
    endtask

    // poll one register bit until it reaches the level
    task automatic wait_reg_bit(addr_t addr, int bit_idx, logic level, string what);
        data_t got;
        int    n;
        n = 0;
        do begin
            bus_access(1'b0, addr, '0, got);
            n++;
        end while (got[bit_idx] != level && n < TIMEOUT);
        if (got[bit_idx] != level) begin
            $display("timeout waiting for %s to become %0d", what, level);
            timeout_count++;
        end
    endtask

    task automatic wait_irq(logic level);
        int n;
        n = 0;
        while (irq != level && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (irq != level) begin
            $display("timeout waiting for irq to become %0d", level);
            timeout_count++;
        end
    endtask

    task automatic check_model_regs(string when);
        read_expect({"cfg ctrl ", when}, reg_addr(REG_SYSCFG, CFG_CTRL));
        read_expect({"cfg irq_en ", when}, reg_addr(REG_SYSCFG, CFG_IRQ_EN));
        for (int p = 0; p < 2; p++) begin
            read_expect($sformatf("periph %0d compare %s", p, when), periph_addr(p, PER_COMPARE));
            read_expect($sformatf("periph %0d ctrl %s", p, when), periph_addr(p, PER_CTRL));
            read_expect($sformatf("periph %0d gpio %s", p, when), periph_addr(p, PER_GPIO));
        end
        check_equal({"lspa_gpio ", when}, data_t'(lspa_gpio), data_t'(m_gpio[0]));
        check_equal({"lspb_gpio ", when}, data_t'(lspb_gpio), data_t'(m_gpio[1]));
    endtask

    initial begin
        data_t   rnd;
        data_t   first;
        data_t   second;
        addr_t   addr;
        offset_t per_off;

        apply_reset();
        check_equal("rsp.valid after reset", data_t'(rsp.valid), '0);
        check_equal("irq after reset", data_t'(irq), '0);
        check_model_regs("after reset");

        // random writes and read-backs
        for (int i = 0; i < 60; i++) begin
            rnd     = next_random();
            per_off = rnd[4] ? PER_COMPARE : PER_GPIO;
            case (rnd[1:0])
                2'd0:    addr = reg_addr(REG_SYSCFG, CFG_IRQ_EN);
                2'd1:    addr = periph_addr(0, per_off);
                default: addr = periph_addr(1, per_off);
            endcase
            if (rnd[3]) begin
                write_reg(addr, next_random());
            end
            read_expect($sformatf("random %h", addr), addr);
        end
        check_model_regs("after random traffic");

        // unmapped region at offsets used by the mapped registers
        for (int i = 0; i < 8; i++) begin
            rnd  = next_random();
            addr = reg_addr(REG_NONE, offset_t'({rnd[4:2], 2'b00}));
            write_reg(addr, next_random());
            read_expect($sformatf("unmapped %h", addr), addr);
        end
        check_model_regs("after unmapped accesses");

        // pause lspb while both timers run
        write_reg(periph_addr(0, PER_COMPARE), 32'h0010_0000);
        write_reg(periph_addr(1, PER_COMPARE), 32'h0010_0000);
        write_reg(periph_addr(0, PER_CTRL), 32'h1);
        write_reg(periph_addr(1, PER_CTRL), 32'h1);
        write_reg(reg_addr(REG_SYSCFG, CFG_CTRL), 32'h8);
        wait_reg_bit(reg_addr(REG_SYSCFG, CFG_STATUS), 1, 1'b1, "lspb pause status");
        bus_access(1'b0, periph_addr(1, PER_COUNT), '0, first);
        bus_access(1'b0, periph_addr(1, PER_COUNT), '0, second);
        check_equal("rsp.rdata lspb count while paused", second, first);
        bus_access(1'b0, periph_addr(0, PER_COUNT), '0, first);
        bus_access(1'b0, periph_addr(0, PER_COUNT), '0, second);
        check_count++;
        assert (second != first) else begin
            $display("lspa count did not advance while lspb was paused");
            error_count++;
        end
        write_reg(reg_addr(REG_SYSCFG, CFG_CTRL), 32'h0);
        wait_reg_bit(reg_addr(REG_SYSCFG, CFG_STATUS), 1, 1'b0, "lspb pause status");

        // lspa timer interrupt after a soft reset clears its counter
        write_reg(reg_addr(REG_SYSCFG, CFG_CTRL), 32'h1);
        write_reg(reg_addr(REG_SYSCFG, CFG_CTRL), 32'h0);
        write_reg(reg_addr(REG_SYSCFG, CFG_IRQ_EN), 32'h1);
        write_reg(periph_addr(0, PER_COMPARE), (next_random() & 32'hF) + 32'd2);
        write_reg(periph_addr(0, PER_CTRL), 32'h1);
        wait_reg_bit(periph_addr(0, PER_IRQ), 0, 1'b1, "lspa timer flag");
        wait_irq(1'b1);
        write_reg(periph_addr(0, PER_CTRL), 32'h0);
        write_reg(periph_addr(0, PER_IRQ), 32'h1);
        bus_access(1'b0, periph_addr(0, PER_IRQ), '0, first);
        check_equal("rsp.rdata lspa flag after clear", first, 32'h0);
        wait_irq(1'b0);

        // lspb flag set so that the soft reset has something to clear
        write_reg(reg_addr(REG_SYSCFG, CFG_CTRL), 32'h2);
        write_reg(reg_addr(REG_SYSCFG, CFG_CTRL), 32'h0);
        write_reg(periph_addr(1, PER_COMPARE), 32'h20);
        write_reg(periph_addr(1, PER_CTRL), 32'h1);
        wait_reg_bit(periph_addr(1, PER_IRQ), 0, 1'b1, "lspb timer flag");

        // hold lspb in soft reset
        write_reg(reg_addr(REG_SYSCFG, CFG_CTRL), 32'h2);
        read_expect("lspb count in reset", periph_addr(1, PER_COUNT));
        read_expect("lspb flag in reset", periph_addr(1, PER_IRQ));
        write_reg(periph_addr(1, PER_COMPARE), next_random());
        write_reg(periph_addr(1, PER_GPIO), next_random());
        check_model_regs("during lspb reset");
        write_reg(reg_addr(REG_SYSCFG, CFG_CTRL), 32'h0);
        check_model_regs("after lspb reset");

        $display("checks %0d, errors %0d, timeouts %0d", check_count, error_count,
                 timeout_count);
        if (error_count == 0 && timeout_count == 0) begin
            $display("TESTS PASSED");
        end
        else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: sources.f
+incdir+.
adam_cfg_pkg.sv
adam_bus_pkg.sv
adam_fabric.sv
adam_periph.sv
adam_syscfg.sv
adam_lite.sv
tb_adam_lite.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_adam_lite
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "TESTS PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
